//--- dv/motion_system_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol checks bound into up_interface
// strobe count restarts each time synchronized start is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module motion_system_asserts
   import motion_pkg::*;
(
   input logic     clk,
   input logic     reset,
   input logic     start_s,
   input logic     rw_s,
   input logic     data_oe,
   input bus_req_t req
);

   logic strobe;
   logic strobe_seen;

   assign strobe = req.wr | req.rd;

   // set by the first strobe of a transaction
   always_ff @(posedge clk) begin
      if (reset || !start_s) begin
         strobe_seen <= 1'b0;
      end else if (strobe) begin
         strobe_seen <= 1'b1;
      end
   end

   // strobe kind follows the direction given with start
   no_dual_strobe: assert property (@(posedge clk) disable iff (reset)
      strobe |-> (req.rd == rw_s) && (req.wr == !rw_s))
      else $error("strobe does not match RW or both strobes set");

   one_strobe_per_start: assert property (@(posedge clk) disable iff (reset)
      strobe |-> !strobe_seen)
      else $error("second strobe within one start assertion");

   data_only_for_read: assert property (@(posedge clk) disable iff (reset)
      data_oe |-> rw_s)
      else $error("uP_data driven while RW is low");

   data_starts_with_start: assert property (@(posedge clk) disable iff (reset)
      $rose(data_oe) |-> $past(start_s))
      else $error("uP_data driven without start");

   data_released_on_abort: assert property (@(posedge clk) disable iff (reset)
      (data_oe && !start_s) |=> !data_oe)
      else $error("uP_data still driven after start fell");

endmodule

bind up_interface motion_system_asserts asserts_i (
   .clk     (clk),
   .reset   (reset),
   .start_s (start_s),
   .rw_s    (rw_s),
   .data_oe (data_oe),
   .req     (req)
);

//--- dv/motion_system_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for motion_system with default parameters
// units 0,1 are QE and 2,3 are PWM, 4..7 unmapped
// every handshake wait gives up after 200 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module motion_system_tb
   import motion_pkg::*;
;

   logic       CLOCK_50;
   logic       reset;
   logic [1:0] quadrature_A, quadrature_B, quadrature_I;
   logic       async_uP_start, async_uP_handshake_1, async_uP_RW;
   logic       uP_ack, uP_handshake_2;
   wire  [7:0] uP_data;
   logic [1:0] pwm_out, H_bridge_1, H_bridge_2;

   logic [7:0]  data_drv;
   logic        data_en;
   logic [31:0] lfsr;
   int          errors, checks, tests_run;
   logic        hung;

   // reference state
   logic [31:0] ref_count [2];
   logic [31:0] ref_index [2];
   logic [31:0] ref_errors [2];
   logic [1:0]  quad_ab [2];
   logic [31:0] ref_pwm [2][3];

   assign uP_data = data_en ? data_drv : 8'hzz;

   motion_system #(.n_qe(2), .n_pwm(2), .pwm_width(16)) motion_system_i (
      .CLOCK_50             (CLOCK_50),
      .reset                (reset),
      .quadrature_A         (quadrature_A),
      .quadrature_B         (quadrature_B),
      .quadrature_I         (quadrature_I),
      .async_uP_start       (async_uP_start),
      .async_uP_handshake_1 (async_uP_handshake_1),
      .async_uP_RW          (async_uP_RW),
      .uP_ack               (uP_ack),
      .uP_handshake_2       (uP_handshake_2),
      .uP_data              (uP_data),
      .pwm_out              (pwm_out),
      .H_bridge_1           (H_bridge_1),
      .H_bridge_2           (H_bridge_2)
   );

   initial CLOCK_50 = 1'b0;
   always #10 CLOCK_50 = ~CLOCK_50;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h80200003;
      end
      return s >> 1;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // place of {A,B} in the forward sequence 00,10,11,01
   function automatic logic [1:0] ab_position(input logic [1:0] ab);
      case (ab)
         2'b00:   return 2'd0;
         2'b10:   return 2'd1;
         2'b11:   return 2'd2;
         default: return 2'd3;
      endcase
   endfunction

   function automatic logic [1:0] ab_at_position(input logic [1:0] p);
      case (p)
         2'd0:    return 2'b00;
         2'd1:    return 2'b10;
         2'd2:    return 2'b11;
         default: return 2'b01;
      endcase
   endfunction

   // count change for one {A,B} change, a double change counts 0
   function automatic int quad_delta(input logic [1:0] from_ab, input logic [1:0] to_ab);
      logic [1:0] d;
      d = ab_position(to_ab) - ab_position(from_ab);
      case (d)
         2'd1:    return 1;
         2'd3:    return -1;
         default: return 0;
      endcase
   endfunction

   function automatic logic quad_illegal(input logic [1:0] from_ab, input logic [1:0] to_ab);
      return (from_ab ^ to_ab) == 2'b11;
   endfunction

   // expected {pwm_out, H_bridge_1, H_bridge_2}
   function automatic logic [2:0] pwm_outputs(input logic [2:0] ctrl, input logic pwm_on);
      if (!ctrl[PWM_CTRL_ENABLE]) begin
         return 3'b000;
      end
      if (ctrl[PWM_CTRL_BRAKE]) begin
         return 3'b011;
      end
      if (ctrl[PWM_CTRL_REVERSE]) begin
         return {pwm_on, 1'b0, pwm_on};
      end
      return {pwm_on, pwm_on, 1'b0};
   endfunction

   function automatic int pwm_high_cycles(input logic [2:0] ctrl, input logic [15:0] on_time);
      if (ctrl[PWM_CTRL_ENABLE] && !ctrl[PWM_CTRL_BRAKE]) begin
         return 2 * int'(on_time);
      end
      return 0;
   endfunction

   task automatic tick();
      @(posedge CLOCK_50);
      #1;
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - errors_before);
      end
   endtask

   task automatic wait_for(input logic on_ack, input logic level);
      int   n;
      logic v;
      n = 0;
      v = on_ack ? uP_ack : uP_handshake_2;
      while (!hung && v !== level && n < 200) begin
         tick();
         n++;
         v = on_ack ? uP_ack : uP_handshake_2;
      end
      if (!hung && v !== level) begin
         hung = 1'b1;
         errors++;
         $display("timeout: %s did not go to %0d within 200 cycles",
                  on_ack ? "uP_ack" : "uP_handshake_2", level);
      end
   endtask

   task automatic send_byte(input logic [7:0] b);
      data_drv             = b;
      data_en              = 1'b1;
      async_uP_handshake_1 = 1'b1;
      wait_for(1'b0, 1'b1);
      async_uP_handshake_1 = 1'b0;
      wait_for(1'b0, 1'b0);
      data_en = 1'b0;
   endtask

   // ack must stay up until start is dropped
   task automatic end_transaction();
      wait_for(1'b1, 1'b1);
      repeat (3) tick();
      if (!hung) begin
         check_value("uP_ack", 32'd1, 32'(uP_ack));
      end
      async_uP_start = 1'b0;
      wait_for(1'b1, 1'b0);
   endtask

   task automatic bus_write(input unit_t unit, input reg_sel_t rs, input logic [31:0] data);
      int i;
      if (!hung) begin
         async_uP_start = 1'b1;
         async_uP_RW    = 1'b0;
         send_byte({1'b0, unit, 2'b00, rs});
         for (i = 3; i >= 0; i--) begin
            send_byte(data[i*8 +: 8]);
         end
         end_transaction();
      end
   endtask

   task automatic bus_read(input unit_t unit, input reg_sel_t rs, output logic [31:0] data);
      int i;
      data = '0;
      if (!hung) begin
         async_uP_start = 1'b1;
         async_uP_RW    = 1'b1;
         send_byte({1'b0, unit, 2'b00, rs});
         for (i = 0; i < 4; i++) begin
            async_uP_handshake_1 = 1'b1;
            wait_for(1'b0, 1'b1);
            data                 = {data[23:0], uP_data};
            async_uP_handshake_1 = 1'b0;
            wait_for(1'b0, 1'b0);
         end
         end_transaction();
      end
   endtask

   task automatic read_and_check(input int unit, input int rs, input logic [31:0] expected);
      logic [31:0] d;
      bus_read(unit_t'(unit), reg_sel_t'(rs), d);
      check_value($sformatf("rdata unit %0d reg %0d", unit, rs), expected, d);
   endtask

   task automatic apply_quad(input int ch, input logic [1:0] ab);
      ref_count[ch] = ref_count[ch] + quad_delta(quad_ab[ch], ab);
      if (quad_illegal(quad_ab[ch], ab)) begin
         ref_errors[ch] = ref_errors[ch] + 32'd1;
      end
      quad_ab[ch]      = ab;
      quadrature_A[ch] = ab[1];
      quadrature_B[ch] = ab[0];
      repeat (6) tick();
   endtask

   task automatic legal_step(input int ch);
      logic [1:0] p;
      p = ab_position(quad_ab[ch]);
      if (rand_bits(1) == 32'd1) begin
         p = p + 2'd1;
      end else begin
         p = p - 2'd1;
      end
      apply_quad(ch, ab_at_position(p));
   endtask

   task automatic verify_pwm_registers();
      int ch, r;
      for (ch = 0; ch < 2; ch++) begin
         for (r = 0; r < 3; r++) begin
            read_and_check(2 + ch, r, ref_pwm[ch][r]);
         end
      end
   endtask

   task automatic test_reset_state();
      int e0, u, r;
      e0 = errors;
      check_value("pwm_out", 32'd0, 32'(pwm_out));
      check_value("H_bridge_1", 32'd0, 32'(H_bridge_1));
      check_value("H_bridge_2", 32'd0, 32'(H_bridge_2));
      check_value("uP_ack", 32'd0, 32'(uP_ack));
      check_value("uP_handshake_2", 32'd0, 32'(uP_handshake_2));
      check_value("uP_data", {24'h0, 8'hzz}, {24'h0, uP_data});
      for (u = 0; u < 4; u++) begin
         for (r = 0; r < 3; r++) begin
            read_and_check(u, r, 32'd0);
         end
      end
      finish_test("reset state", e0);
   endtask

   task automatic test_pwm_registers();
      int          e0, ch, r, u;
      logic [31:0] v;
      e0 = errors;
      for (ch = 0; ch < 2; ch++) begin
         ref_pwm[ch][0] = rand_bits(16);
         ref_pwm[ch][1] = rand_bits(16);
         ref_pwm[ch][2] = rand_bits(3);
         for (r = 0; r < 3; r++) begin
            bus_write(unit_t'(2 + ch), reg_sel_t'(r), ref_pwm[ch][r]);
         end
      end
      verify_pwm_registers();
      // unmapped units drop writes and read 0
      for (u = 4; u < 8; u++) begin
         v = rand_bits(32);
         r = int'(rand_bits(2));
         bus_write(unit_t'(u), reg_sel_t'(r), v);
         read_and_check(u, r, 32'd0);
      end
      verify_pwm_registers();
      for (ch = 0; ch < 2; ch++) begin
         bus_write(unit_t'(2 + ch), PWM_REG_CONTROL, 32'd0);
         ref_pwm[ch][2] = 32'd0;
      end
      finish_test("pwm registers", e0);
   endtask

   task automatic test_pwm_timing();
      int          e0, m, c, high, mism;
      logic [15:0] period, on_time;
      logic [2:0]  ctrl, exp;
      e0      = errors;
      period  = 16'(4 + rand_bits(5));
      on_time = 16'(rand_bits(6) % (32'(period) + 32'd1));
      bus_write(unit_t'(2), PWM_REG_PERIOD, 32'(period));
      bus_write(unit_t'(2), PWM_REG_ON_TIME, 32'(on_time));
      // forward, reverse, brake over reverse, disabled
      for (m = 0; m < 4; m++) begin
         case (m)
            0:       ctrl = 3'b001;
            1:       ctrl = 3'b011;
            2:       ctrl = 3'b111;
            default: ctrl = 3'b110;
         endcase
         bus_write(unit_t'(2), PWM_REG_CONTROL, 32'(ctrl));
         high = 0;
         mism = 0;
         for (c = 0; c < 2 * int'(period); c++) begin
            if (pwm_out[0]) begin
               high++;
            end
            exp = pwm_outputs(ctrl, pwm_out[0]);
            if ({pwm_out[0], H_bridge_1[0], H_bridge_2[0]} !== exp) begin
               mism++;
            end
            tick();
         end
         check_value($sformatf("pwm_out[0] high cycles, control %h", ctrl),
                     32'(pwm_high_cycles(ctrl, on_time)), 32'(high));
         check_value($sformatf("H_bridge[0] mismatch cycles, control %h", ctrl),
                     32'd0, 32'(mism));
      end
      finish_test("pwm timing", e0);
   endtask

   task automatic test_quad_walk();
      int          e0, ch, i;
      logic [31:0] preset;
      e0 = errors;
      for (ch = 0; ch < 2; ch++) begin
         for (i = 0; i < 24; i++) begin
            legal_step(ch);
         end
         read_and_check(ch, QE_REG_COUNT, ref_count[ch]);
         preset = rand_bits(32);
         bus_write(unit_t'(ch), QE_REG_COUNT, preset);
         ref_count[ch] = preset;
         for (i = 0; i < 16; i++) begin
            legal_step(ch);
         end
         read_and_check(ch, QE_REG_COUNT, ref_count[ch]);
         read_and_check(ch, QE_REG_ERRORS, ref_errors[ch]);
      end
      finish_test("quadrature walk", e0);
   endtask

   task automatic test_quad_errors_index();
      int e0, i;
      e0 = errors;
      for (i = 0; i < 3; i++) begin
         legal_step(0);
         apply_quad(0, quad_ab[0] ^ 2'b11);
      end
      read_and_check(0, QE_REG_COUNT, ref_count[0]);
      read_and_check(0, QE_REG_ERRORS, ref_errors[0]);
      bus_write(unit_t'(0), QE_REG_ERRORS, rand_bits(32));
      ref_errors[0] = 32'd0;
      read_and_check(0, QE_REG_ERRORS, ref_errors[0]);
      for (i = 0; i < 3; i++) begin
         legal_step(0);
      end
      quadrature_I[0] = 1'b1;
      repeat (6) tick();
      ref_index[0]    = ref_count[0];
      quadrature_I[0] = 1'b0;
      repeat (6) tick();
      legal_step(0);
      read_and_check(0, QE_REG_INDEX, ref_index[0]);
      read_and_check(0, QE_REG_COUNT, ref_count[0]);
      finish_test("quadrature errors and index", e0);
   endtask

   task automatic test_back_to_back();
      int e0;
      e0             = errors;
      ref_pwm[1][0]  = rand_bits(16);
      bus_write(unit_t'(3), PWM_REG_PERIOD, ref_pwm[1][0]);
      read_and_check(0, QE_REG_COUNT, ref_count[0]);
      read_and_check(3, PWM_REG_PERIOD, ref_pwm[1][0]);
      read_and_check(1, QE_REG_COUNT, ref_count[1]);
      // link stays quiet once start is down
      repeat (4) tick();
      check_value("uP_ack", 32'd0, 32'(uP_ack));
      check_value("uP_handshake_2", 32'd0, 32'(uP_handshake_2));
      check_value("uP_data", {24'h0, 8'hzz}, {24'h0, uP_data});
      finish_test("back to back transactions", e0);
   endtask

   initial begin : main
      int i;
      reset                = 1'b1;
      quadrature_A         = '0;
      quadrature_B         = '0;
      quadrature_I         = '0;
      async_uP_start       = 1'b0;
      async_uP_handshake_1 = 1'b0;
      async_uP_RW          = 1'b0;
      data_drv             = '0;
      data_en              = 1'b0;
      lfsr                 = 32'hcfbc;
      errors               = 0;
      checks               = 0;
      tests_run            = 0;
      hung                 = 1'b0;
      for (i = 0; i < 2; i++) begin
         ref_count[i]  = '0;
         ref_index[i]  = '0;
         ref_errors[i] = '0;
         quad_ab[i]    = 2'b00;
      end
      repeat (16) tick();
      reset = 1'b0;

      if (!hung) test_reset_state();
      if (!hung) test_pwm_registers();
      if (!hung) test_pwm_timing();
      if (!hung) test_quad_walk();
      if (!hung) test_quad_errors_index();
      if (!hung) test_back_to_back();

      $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- src.f
verilog/motion_pkg.sv
verilog/synchronizer.sv
verilog/up_interface.sv
verilog/register_bus_fabric.sv
verilog/qe_channel.sv
verilog/pwm_channel.sv
verilog/motion_system.sv
dv/motion_system_asserts.sv
dv/motion_system_tb.sv

//--- verilog/motion_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// internal register bus types and address layout
// command byte: bit 7 must be 0, bits 3..2 ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package motion_pkg;

   typedef logic [2:0] unit_t;
   typedef logic [1:0] reg_sel_t;

   // request from the single bus master, strobes last one cycle
   typedef struct packed {
      logic        wr;
      logic        rd;
      unit_t       unit;
      reg_sel_t    reg_sel;
      logic [31:0] wdata;
   } bus_req_t;

   typedef struct packed {
      logic [31:0] rdata;
   } bus_rsp_t;

   // command byte fields
   localparam int CMD_UNIT_MSB = 6;
   localparam int CMD_UNIT_LSB = 4;
   localparam int CMD_REG_MSB  = 1;
   localparam int CMD_REG_LSB  = 0;

   // quadrature encoder registers
   localparam reg_sel_t QE_REG_COUNT  = 2'd0;
   localparam reg_sel_t QE_REG_INDEX  = 2'd1;
   localparam reg_sel_t QE_REG_ERRORS = 2'd2;

   // pwm registers
   localparam reg_sel_t PWM_REG_PERIOD  = 2'd0;
   localparam reg_sel_t PWM_REG_ON_TIME = 2'd1;
   localparam reg_sel_t PWM_REG_CONTROL = 2'd2;

   // pwm control bits
   localparam int PWM_CTRL_ENABLE  = 0;
   localparam int PWM_CTRL_REVERSE = 1;
   localparam int PWM_CTRL_BRAKE   = 2;

endpackage

//--- verilog/motion_system.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// motion control registers behind the uP byte bus
// all uP and encoder inputs are synchronized inside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module motion_system
   import motion_pkg::*;
#(
   parameter int n_qe      = 2,
   parameter int n_pwm     = 2,
   parameter int pwm_width = 16
) (
   input  logic             CLOCK_50,
   input  logic             reset,
   input  logic [n_qe-1:0]  quadrature_A,
   input  logic [n_qe-1:0]  quadrature_B,
   input  logic [n_qe-1:0]  quadrature_I,
   input  logic             async_uP_start,
   input  logic             async_uP_handshake_1,
   input  logic             async_uP_RW,
   output logic             uP_ack,
   output logic             uP_handshake_2,
   inout  wire  [7:0]       uP_data,
   output logic [n_pwm-1:0] pwm_out,
   output logic [n_pwm-1:0] H_bridge_1,
   output logic [n_pwm-1:0] H_bridge_2
);

   bus_req_t         m_req, s_req;
   bus_rsp_t         m_rsp;
   bus_rsp_t         qe_rsp [n_qe];
   bus_rsp_t         pwm_rsp [n_pwm];
   logic [n_qe-1:0]  qe_sel;
   logic [n_pwm-1:0] pwm_sel;

   up_interface up_interface_sys (
      .clk            (CLOCK_50),
      .reset          (reset),
      .uP_start       (async_uP_start),
      .uP_handshake_1 (async_uP_handshake_1),
      .uP_RW          (async_uP_RW),
      .uP_ack         (uP_ack),
      .uP_handshake_2 (uP_handshake_2),
      .uP_data        (uP_data),
      .req            (m_req),
      .rsp            (m_rsp)
   );

   register_bus_fabric #(.n_qe(n_qe), .n_pwm(n_pwm)) fabric (
      .m_req   (m_req),
      .m_rsp   (m_rsp),
      .qe_sel  (qe_sel),
      .pwm_sel (pwm_sel),
      .s_req   (s_req),
      .qe_rsp  (qe_rsp),
      .pwm_rsp (pwm_rsp)
   );

   for (genvar i = 0; i < n_qe; i++) begin : qe_ch
      qe_channel qe (
         .clk        (CLOCK_50),
         .reset      (reset),
         .sel        (qe_sel[i]),
         .req        (s_req),
         .rsp        (qe_rsp[i]),
         .async_qe_a (quadrature_A[i]),
         .async_qe_b (quadrature_B[i]),
         .async_qe_i (quadrature_I[i])
      );
   end

   for (genvar i = 0; i < n_pwm; i++) begin : pwm_ch
      pwm_channel #(.pwm_width(pwm_width)) pwm (
         .clk        (CLOCK_50),
         .reset      (reset),
         .sel        (pwm_sel[i]),
         .req        (s_req),
         .rsp        (pwm_rsp[i]),
         .pwm_signal (pwm_out[i]),
         .H_bridge_1 (H_bridge_1[i]),
         .H_bridge_2 (H_bridge_2[i])
      );
   end

endmodule

//--- verilog/pwm_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pwm with H-bridge steering, outputs are registered
// period and on_time keep only the low pwm_width bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module pwm_channel
   import motion_pkg::*;
#(
   parameter int pwm_width = 16
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     sel,
   input  bus_req_t req,
   output bus_rsp_t rsp,
   output logic     pwm_signal,
   output logic     H_bridge_1,
   output logic     H_bridge_2
);

   logic [pwm_width-1:0] period, on_time, cnt;
   logic [2:0]           control;
   logic                 active, pwm_raw;

   assign active  = control[PWM_CTRL_ENABLE] && (period != '0);
   assign pwm_raw = active && (cnt < on_time);

   always_ff @(posedge clk) begin
      if (reset) begin
         period  <= '0;
         on_time <= '0;
         control <= '0;
      end else if (sel && req.wr) begin
         case (req.reg_sel)
            PWM_REG_PERIOD:  period  <= req.wdata[pwm_width-1:0];
            PWM_REG_ON_TIME: on_time <= req.wdata[pwm_width-1:0];
            PWM_REG_CONTROL: control <= req.wdata[2:0];
            default: ;
         endcase
      end
   end

   // wraps early if period is lowered below the running count
   always_ff @(posedge clk) begin
      if (reset || !active) begin
         cnt <= '0;
      end else if (cnt >= period - 1'b1) begin
         cnt <= '0;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || !active) begin
         pwm_signal <= 1'b0;
         H_bridge_1 <= 1'b0;
         H_bridge_2 <= 1'b0;
      end else if (control[PWM_CTRL_BRAKE]) begin
         pwm_signal <= 1'b0;
         H_bridge_1 <= 1'b1;
         H_bridge_2 <= 1'b1;
      end else if (control[PWM_CTRL_REVERSE]) begin
         pwm_signal <= pwm_raw;
         H_bridge_1 <= 1'b0;
         H_bridge_2 <= pwm_raw;
      end else begin
         pwm_signal <= pwm_raw;
         H_bridge_1 <= pwm_raw;
         H_bridge_2 <= 1'b0;
      end
   end

   always_comb begin
      case (req.reg_sel)
         PWM_REG_PERIOD:  rsp.rdata = 32'(period);
         PWM_REG_ON_TIME: rsp.rdata = 32'(on_time);
         PWM_REG_CONTROL: rsp.rdata = 32'(control);
         default:         rsp.rdata = '0;
      endcase
   end

endmodule

//--- verilog/qe_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// quadrature decoder, one count per {A,B} change
// inputs must be stable for more than 2 clocks per step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module qe_channel
   import motion_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     sel,
   input  bus_req_t req,
   output bus_rsp_t rsp,
   input  logic     async_qe_a,
   input  logic     async_qe_b,
   input  logic     async_qe_i
);

   logic               a_s, b_s, i_s;
   logic               i_prev;
   logic [1:0]         phase, phase_prev, step;
   logic               wr_hit;
   logic signed [31:0] count;
   logic [31:0]        index_count;
   logic [31:0]        errors;

   synchronizer sync_a (.clk(clk), .reset(reset), .async_in(async_qe_a), .sync_out(a_s));
   synchronizer sync_b (.clk(clk), .reset(reset), .async_in(async_qe_b), .sync_out(b_s));
   synchronizer sync_i (.clk(clk), .reset(reset), .async_in(async_qe_i), .sync_out(i_s));

   // 00,10,11,01 map to phase 0..3
   assign phase  = {b_s, a_s ^ b_s};
   assign step   = phase - phase_prev;
   assign wr_hit = sel && req.wr;

   always_ff @(posedge clk) begin
      if (reset) begin
         phase_prev  <= 2'd0;
         i_prev      <= 1'b0;
         count       <= '0;
         index_count <= '0;
         errors      <= '0;
      end else begin
         phase_prev <= phase;
         i_prev     <= i_s;

         if (i_s && !i_prev) begin
            index_count <= count;
         end

         // bus write wins over a step in the same cycle
         if (wr_hit && (req.reg_sel == QE_REG_COUNT)) begin
            count <= signed'(req.wdata);
         end else if (step == 2'd1) begin
            count <= count + 32'sd1;
         end else if (step == 2'd3) begin
            count <= count - 32'sd1;
         end

         // step of 2 means both bits moved
         if (wr_hit && (req.reg_sel == QE_REG_ERRORS)) begin
            errors <= '0;
         end else if (step == 2'd2) begin
            errors <= errors + 32'd1;
         end
      end
   end

   always_comb begin
      case (req.reg_sel)
         QE_REG_COUNT:  rsp.rdata = count;
         QE_REG_INDEX:  rsp.rdata = index_count;
         QE_REG_ERRORS: rsp.rdata = errors;
         default:       rsp.rdata = '0;
      endcase
   end

endmodule

//--- verilog/register_bus_fabric.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// units 0..n_qe-1 are QE, next n_pwm are PWM
// n_qe + n_pwm must not exceed 8, higher units read 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module register_bus_fabric
   import motion_pkg::*;
#(
   parameter int n_qe  = 2,
   parameter int n_pwm = 2
) (
   input  bus_req_t         m_req,
   output bus_rsp_t         m_rsp,
   output logic [n_qe-1:0]  qe_sel,
   output logic [n_pwm-1:0] pwm_sel,
   output bus_req_t         s_req,
   input  bus_rsp_t         qe_rsp [n_qe],
   input  bus_rsp_t         pwm_rsp [n_pwm]
);

   logic access;

   assign access = m_req.wr | m_req.rd;
   assign s_req  = m_req;

   // select only during a strobe, read data follows the unit field
   always_comb begin
      m_rsp = '0;
      for (int i = 0; i < n_qe; i++) begin
         qe_sel[i] = access && (m_req.unit == unit_t'(i));
         if (m_req.unit == unit_t'(i)) begin
            m_rsp = qe_rsp[i];
         end
      end
      for (int i = 0; i < n_pwm; i++) begin
         pwm_sel[i] = access && (m_req.unit == unit_t'(n_qe + i));
         if (m_req.unit == unit_t'(n_qe + i)) begin
            m_rsp = pwm_rsp[i];
         end
      end
   end

endmodule

//--- verilog/synchronizer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two flop synchronizer, output lags input by 2 clocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module synchronizer (
   input  logic clk,
   input  logic reset,
   input  logic async_in,
   output logic sync_out
);

   logic meta;

   always_ff @(posedge clk) begin
      if (reset) begin
         meta     <= 1'b0;
         sync_out <= 1'b0;
      end else begin
         meta     <= async_in;
         sync_out <= meta;
      end
   end

endmodule

//--- verilog/up_interface.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte link to the microprocessor, four phase handshake
// start, handshake_1 and RW are asynchronous to clk
// uP_data is sampled once handshake_1 is seen high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module up_interface
   import motion_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       uP_start,
   input  logic       uP_handshake_1,
   input  logic       uP_RW,
   output logic       uP_ack,
   output logic       uP_handshake_2,
   inout  wire  [7:0] uP_data,
   output bus_req_t   req,
   input  bus_rsp_t   rsp
);

   typedef enum logic [3:0] {
      S_IDLE,
      S_CMD_WAIT,
      S_CMD_REL,
      S_WR_WAIT,
      S_WR_REL,
      S_WR_STROBE,
      S_RD_STROBE,
      S_RD_WAIT,
      S_RD_HS2,
      S_RD_REL,
      S_ACK_WAIT,
      S_ACK_END
   } state_t;

   state_t      state;
   logic        start_s, hs1_s, rw_s;
   logic [1:0]  byte_cnt;
   logic        data_oe;
   logic        abortable;
   unit_t       cmd_unit;
   reg_sel_t    cmd_reg;
   logic [31:0] shift;

   synchronizer sync_start (.clk(clk), .reset(reset), .async_in(uP_start), .sync_out(start_s));
   synchronizer sync_hs1 (.clk(clk), .reset(reset), .async_in(uP_handshake_1), .sync_out(hs1_s));
   synchronizer sync_rw (.clk(clk), .reset(reset), .async_in(uP_RW), .sync_out(rw_s));

   // losing start here drops the transaction, strobe and ack states run to the end
   assign abortable = (state == S_CMD_WAIT) || (state == S_CMD_REL) ||
                      (state == S_WR_WAIT)  || (state == S_WR_REL)  ||
                      (state == S_RD_WAIT)  || (state == S_RD_HS2)  ||
                      (state == S_RD_REL);

   always_ff @(posedge clk) begin
      if (reset) begin
         state          <= S_IDLE;
         byte_cnt       <= 2'd0;
         data_oe        <= 1'b0;
         uP_handshake_2 <= 1'b0;
         uP_ack         <= 1'b0;
      end else if (abortable && !start_s) begin
         state          <= S_IDLE;
         data_oe        <= 1'b0;
         uP_handshake_2 <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               byte_cnt <= 2'd0;
               if (start_s) state <= S_CMD_WAIT;
            end
            S_CMD_WAIT: begin
               if (hs1_s) begin
                  uP_handshake_2 <= 1'b1;
                  state          <= S_CMD_REL;
               end
            end
            S_CMD_REL: begin
               if (!hs1_s) begin
                  uP_handshake_2 <= 1'b0;
                  state          <= rw_s ? S_RD_STROBE : S_WR_WAIT;
               end
            end
            S_WR_WAIT: begin
               if (hs1_s) begin
                  uP_handshake_2 <= 1'b1;
                  state          <= S_WR_REL;
               end
            end
            S_WR_REL: begin
               if (!hs1_s) begin
                  uP_handshake_2 <= 1'b0;
                  byte_cnt       <= byte_cnt + 2'd1;
                  state          <= (byte_cnt == 2'd3) ? S_WR_STROBE : S_WR_WAIT;
               end
            end
            S_WR_STROBE: begin
               uP_ack <= 1'b1;
               state  <= S_ACK_WAIT;
            end
            S_RD_STROBE: state <= S_RD_WAIT;
            S_RD_WAIT: begin
               if (hs1_s) begin
                  data_oe <= 1'b1;
                  state   <= S_RD_HS2;
               end
            end
            // byte has been on the pins for one cycle
            S_RD_HS2: begin
               uP_handshake_2 <= 1'b1;
               state          <= S_RD_REL;
            end
            S_RD_REL: begin
               if (!hs1_s) begin
                  uP_handshake_2 <= 1'b0;
                  data_oe        <= 1'b0;
                  byte_cnt       <= byte_cnt + 2'd1;
                  if (byte_cnt == 2'd3) begin
                     uP_ack <= 1'b1;
                     state  <= S_ACK_WAIT;
                  end else begin
                     state <= S_RD_WAIT;
                  end
               end
            end
            S_ACK_WAIT: begin
               if (!start_s) state <= S_ACK_END;
            end
            S_ACK_END: begin
               uP_ack <= 1'b0;
               state  <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // command fields and the data word, shared by write assembly and read output
   always_ff @(posedge clk) begin
      case (state)
         S_CMD_WAIT: begin
            if (hs1_s) begin
               cmd_unit <= uP_data[CMD_UNIT_MSB:CMD_UNIT_LSB];
               cmd_reg  <= uP_data[CMD_REG_MSB:CMD_REG_LSB];
            end
         end
         S_WR_WAIT: if (hs1_s) shift <= {shift[23:0], uP_data};
         S_RD_STROBE: shift <= rsp.rdata;
         S_RD_REL: if (!hs1_s) shift <= {shift[23:0], 8'h00};
         default: ;
      endcase
   end

   always_comb begin
      req.wr      = (state == S_WR_STROBE);
      req.rd      = (state == S_RD_STROBE);
      req.unit    = cmd_unit;
      req.reg_sel = cmd_reg;
      req.wdata   = shift;
   end

   // msb first
   assign uP_data = data_oe ? shift[31:24] : 8'hzz;

endmodule
